//--- rv_cfg.svh
// Core configuration macros: word width, register count, reset vector, memory depth
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address word width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Depth of the external memory in words
`define RV_MEM_WORDS 1024

`endif

//--- rv_pkg.sv
// Shared types for the multicycle RV32I core: control enums and bus structs
`include "rv_cfg.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
    } imm_src_e;

    typedef enum logic [2:0] {
        ALU_SRC_REG_1, ALU_SRC_REG_2, ALU_SRC_EXT_IMM,
        ALU_SRC_PC, ALU_SRC_PC_OLD, ALU_SRC_CONST_4
    } alu_src_e;

    typedef enum logic {
        RES_SRC_ALU_OUT,  // Registered ALU output
        RES_SRC_MEM       // Registered read data
    } res_src_e;

    typedef enum logic [1:0] {
        RF_WD_SRC_RES, RF_WD_SRC_PC, RF_WD_SRC_IMM, RF_WD_SRC_NONE
    } rf_wd_src_e;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_MEM_ADDR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
        S_EXEC_R, S_EXEC_I, S_ALU_WB, S_BRANCH, S_JAL, S_LUI
    } fsm_state_e;

    typedef struct packed {
        logic zero;
        logic neg;
        logic carry;  // No borrow out of a - b
        logic ovf;
    } alu_flags_t;

    // All datapath selects and enables, 20 bits
    typedef struct packed {
        logic       rf_we;
        imm_src_e   imm_src;
        alu_op_e    alu_ctrl;
        alu_src_e   alu_src_a;
        alu_src_e   alu_src_b;
        res_src_e   res_src;
        logic       addr_src;    // 0 = PC, 1 = result
        logic       en_ir;
        logic       en_npc_r;
        logic       en_oldpc_r;
        rf_wd_src_e rf_wd_src;
    } dp_ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wd;
        logic                we;
    } mem_req_t;

endpackage

//--- alu.sv
// ALU with eight RV32I operations and compare flags from the subtract path
`timescale 1ns/1ps
`include "rv_cfg.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_e     op,
    output logic [`RV_XLEN-1:0] y,
    output rv_pkg::alu_flags_t  flags
);
    logic [`RV_XLEN:0]   diff_ext;  // Carry out on top
    logic [`RV_XLEN-1:0] diff;
    logic [4:0]          shamt;

    // a - b as a + ~b + 1
    assign diff_ext = {1'b0, a} + {1'b0, ~b} + {{`RV_XLEN{1'b0}}, 1'b1};
    assign diff     = diff_ext[`RV_XLEN-1:0];
    assign shamt    = b[4:0];                 // Shifts only use the low five bits

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: y = a + b;
            rv_pkg::ALU_SUB: y = diff;
            rv_pkg::ALU_AND: y = a & b;
            rv_pkg::ALU_OR:  y = a | b;
            rv_pkg::ALU_XOR: y = a ^ b;
            rv_pkg::ALU_SLT: y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLL: y = a << shamt;
            rv_pkg::ALU_SRL: y = a >> shamt;
            default:         y = '0;
        endcase
    end

    // Flags always describe a - b, whatever op is selected
    assign flags.zero  = (diff == '0);
    assign flags.neg   = diff[`RV_XLEN-1];
    assign flags.carry = diff_ext[`RV_XLEN];
    assign flags.ovf   = (a[`RV_XLEN-1] != b[`RV_XLEN-1]) &&
                         (diff[`RV_XLEN-1] != a[`RV_XLEN-1]);  // Sign flip on unlike signs

endmodule

//--- extend.sv
// Immediate extender rebuilding and sign-extending I, S, B, J and U fields
`timescale 1ns/1ps
`include "rv_cfg.svh"

module extend (
    input  logic [`RV_XLEN-1:0] instr,
    input  rv_pkg::imm_src_e    imm_src,
    output logic [`RV_XLEN-1:0] imm
);
    logic sign;

    assign sign = instr[31];  // Immediate sign always sits in bit 31

    always_comb begin
        case (imm_src)
            rv_pkg::IMM_I: imm = {{20{sign}}, instr[31:20]};
            rv_pkg::IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offset, halfword aligned
            rv_pkg::IMM_B: imm = {{19{sign}}, sign, instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            // Jump offset, halfword aligned
            rv_pkg::IMM_J: imm = {{11{sign}}, sign, instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            rv_pkg::IMM_U: imm = {instr[31:12], 12'b0};  // Upper 20 bits
            default:       imm = '0;
        endcase
    end

endmodule

//--- regfile.sv
// Register file with two combinational reads, one clocked write, x0 tied to zero
`timescale 1ns/1ps
`include "rv_cfg.svh"

module regfile (
    input  logic                         clk,
    input  logic [$clog2(`RV_NREGS)-1:0] ra1,
    input  logic [$clog2(`RV_NREGS)-1:0] ra2,
    input  logic [$clog2(`RV_NREGS)-1:0] wa,
    input  logic [`RV_XLEN-1:0]          wd,
    input  logic                         we,
    output logic [`RV_XLEN-1:0]          rd1,
    output logic [`RV_XLEN-1:0]          rd2
);
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (we && (wa != '0))  // x0 never written
            regs[wa] <= wd;
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- datapath_multicycle.sv
// Multicycle datapath with PC, IR, operand and result registers around one ALU
`timescale 1ns/1ps
`include "rv_cfg.svh"

module datapath_multicycle (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::dp_ctrl_t    ctrl,
    input  logic [`RV_XLEN-1:0] m_rd,
    output logic [`RV_XLEN-1:0] m_addr,
    output logic [`RV_XLEN-1:0] m_wd,
    output logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] pc,
    output rv_pkg::alu_flags_t  alu_flags
);
    logic [`RV_XLEN-1:0] pc_old;     // PC of the instruction in IR
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] m_rd_r;     // Load data
    logic [`RV_XLEN-1:0] rd1;        // Registered operands
    logic [`RV_XLEN-1:0] rd2;
    logic [`RV_XLEN-1:0] reg_rd1;
    logic [`RV_XLEN-1:0] reg_rd2;
    logic [`RV_XLEN-1:0] reg_wd;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] ext_imm;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] alu_out_r;

    // Shared operand select for both ALU inputs
    function automatic logic [`RV_XLEN-1:0] operand(input rv_pkg::alu_src_e src);
        logic [`RV_XLEN-1:0] val;
        case (src)
            rv_pkg::ALU_SRC_REG_1:   val = rd1;
            rv_pkg::ALU_SRC_REG_2:   val = rd2;
            rv_pkg::ALU_SRC_EXT_IMM: val = ext_imm;
            rv_pkg::ALU_SRC_PC:      val = pc;
            rv_pkg::ALU_SRC_PC_OLD:  val = pc_old;
            rv_pkg::ALU_SRC_CONST_4: val = `RV_XLEN'd4;
            default:                 val = '0;
        endcase
        return val;
    endfunction

    always_comb begin
        case (ctrl.res_src)
            rv_pkg::RES_SRC_ALU_OUT: result = alu_out_r;
            rv_pkg::RES_SRC_MEM:     result = m_rd_r;
            default:                 result = '0;
        endcase
    end

    // Fetch writes PC+4 straight from the ALU, jumps take the registered target
    assign pc_next = ctrl.en_ir ? alu_y : result;

    assign m_addr = ctrl.addr_src ? result : pc;
    assign m_wd   = rd2;                       // Store data is rs2

    // PC, old PC and instruction, each with its own enable
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `RV_RESET_PC;
            pc_old <= '0;
            instr  <= '0;
        end else begin
            if (ctrl.en_npc_r)
                pc <= pc_next;
            if (ctrl.en_oldpc_r)
                pc_old <= pc;  // Same edge as the PC+4 update
            if (ctrl.en_ir)
                instr <= m_rd;
        end
    end

    // Free-running stage registers, one cycle behind their source
    always_ff @(posedge clk) begin
        if (reset) begin
            m_rd_r    <= '0;
            rd1       <= '0;
            rd2       <= '0;
            alu_out_r <= '0;
        end else begin
            m_rd_r    <= m_rd;
            rd1       <= reg_rd1;
            rd2       <= reg_rd2;
            alu_out_r <= alu_y;
        end
    end

    always_comb begin
        case (ctrl.rf_wd_src)
            rv_pkg::RF_WD_SRC_RES: reg_wd = result;
            rv_pkg::RF_WD_SRC_PC:  reg_wd = pc;       // Already old PC + 4, jal link
            rv_pkg::RF_WD_SRC_IMM: reg_wd = ext_imm;  // lui
            default:               reg_wd = '0;
        endcase
    end

    regfile rf (
        .clk (clk),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .wd  (reg_wd),
        .we  (ctrl.rf_we),
        .rd1 (reg_rd1),
        .rd2 (reg_rd2)
    );

    extend ext (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (ext_imm)
    );

    always_comb begin
        alu_a = operand(ctrl.alu_src_a);
        alu_b = operand(ctrl.alu_src_b);
    end

    alu alu0 (
        .a     (alu_a),
        .b     (alu_b),
        .op    (ctrl.alu_ctrl),
        .y     (alu_y),
        .flags (alu_flags)
    );

endmodule

//--- control_fsm.sv
// Main decoder FSM and ALU decoder driving the multicycle datapath controls
`timescale 1ns/1ps
`include "rv_cfg.svh"

module control_fsm (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_XLEN-1:0] instr,
    input  rv_pkg::alu_flags_t  flags,
    output rv_pkg::dp_ctrl_t    ctrl,
    output logic                m_we
);
    rv_pkg::fsm_state_e state;
    rv_pkg::fsm_state_e state_next;
    rv_pkg::opcode_e    opcode;
    rv_pkg::alu_op_e    alu_dec;   // Operation for EXEC states
    logic [2:0]         funct3;
    logic [6:0]         funct7;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ALU decoder, sub only exists in R-type
    always_comb begin
        case (funct3)
            3'b000:  alu_dec = (opcode == rv_pkg::OPC_OP && funct7[5]) ?
                               rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_dec = rv_pkg::ALU_SLL;
            3'b010:  alu_dec = rv_pkg::ALU_SLT;
            3'b100:  alu_dec = rv_pkg::ALU_XOR;
            3'b101:  alu_dec = rv_pkg::ALU_SRL;
            3'b110:  alu_dec = rv_pkg::ALU_OR;
            3'b111:  alu_dec = rv_pkg::ALU_AND;
            default: alu_dec = rv_pkg::ALU_ADD;  // sltu not supported
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= rv_pkg::S_FETCH;
        else
            state <= state_next;
    end

    always_comb begin
        case (state)
            rv_pkg::S_FETCH:  state_next = rv_pkg::S_DECODE;
            rv_pkg::S_DECODE: begin
                case (opcode)
                    rv_pkg::OPC_LOAD,
                    rv_pkg::OPC_STORE:  state_next = rv_pkg::S_MEM_ADDR;
                    rv_pkg::OPC_OP:     state_next = rv_pkg::S_EXEC_R;
                    rv_pkg::OPC_OP_IMM: state_next = rv_pkg::S_EXEC_I;
                    rv_pkg::OPC_BRANCH: state_next = rv_pkg::S_BRANCH;
                    rv_pkg::OPC_JAL:    state_next = rv_pkg::S_JAL;
                    rv_pkg::OPC_LUI:    state_next = rv_pkg::S_LUI;
                    default:            state_next = rv_pkg::S_FETCH;  // Skip unknown
                endcase
            end
            rv_pkg::S_MEM_ADDR: state_next = (opcode == rv_pkg::OPC_LOAD) ?
                                             rv_pkg::S_MEM_READ : rv_pkg::S_MEM_WRITE;
            rv_pkg::S_MEM_READ: state_next = rv_pkg::S_MEM_WB;
            rv_pkg::S_EXEC_R,
            rv_pkg::S_EXEC_I:   state_next = rv_pkg::S_ALU_WB;
            default:            state_next = rv_pkg::S_FETCH;
        endcase
    end

    // Moore outputs, everything idle unless the state says otherwise
    always_comb begin
        ctrl.rf_we      = 1'b0;
        ctrl.imm_src    = rv_pkg::IMM_I;
        ctrl.alu_ctrl   = rv_pkg::ALU_ADD;
        ctrl.alu_src_a  = rv_pkg::ALU_SRC_REG_1;
        ctrl.alu_src_b  = rv_pkg::ALU_SRC_REG_2;
        ctrl.res_src    = rv_pkg::RES_SRC_ALU_OUT;
        ctrl.addr_src   = 1'b0;
        ctrl.en_ir      = 1'b0;
        ctrl.en_npc_r   = 1'b0;
        ctrl.en_oldpc_r = 1'b0;
        ctrl.rf_wd_src  = rv_pkg::RF_WD_SRC_NONE;
        m_we            = 1'b0;
        case (state)
            rv_pkg::S_FETCH: begin
                ctrl.en_ir      = 1'b1;                    // IR <= mem[PC]
                ctrl.en_oldpc_r = 1'b1;
                ctrl.en_npc_r   = 1'b1;                    // PC <= PC + 4
                ctrl.alu_src_a  = rv_pkg::ALU_SRC_PC;
                ctrl.alu_src_b  = rv_pkg::ALU_SRC_CONST_4;
            end
            rv_pkg::S_DECODE: begin
                // Precompute old PC + offset for branch and jal
                ctrl.imm_src   = (opcode == rv_pkg::OPC_JAL) ? rv_pkg::IMM_J : rv_pkg::IMM_B;
                ctrl.alu_src_a = rv_pkg::ALU_SRC_PC_OLD;
                ctrl.alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::S_MEM_ADDR: begin
                ctrl.imm_src   = (opcode == rv_pkg::OPC_STORE) ? rv_pkg::IMM_S : rv_pkg::IMM_I;
                ctrl.alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;  // rs1 + offset
            end
            rv_pkg::S_MEM_READ:
                ctrl.addr_src = 1'b1;                      // Address from ALU out
            rv_pkg::S_MEM_WB: begin
                ctrl.res_src   = rv_pkg::RES_SRC_MEM;
                ctrl.rf_wd_src = rv_pkg::RF_WD_SRC_RES;
                ctrl.rf_we     = 1'b1;
            end
            rv_pkg::S_MEM_WRITE: begin
                ctrl.addr_src = 1'b1;
                m_we          = 1'b1;                      // Only write strobe
            end
            rv_pkg::S_EXEC_R:
                ctrl.alu_ctrl = alu_dec;
            rv_pkg::S_EXEC_I: begin
                ctrl.alu_ctrl  = alu_dec;
                ctrl.alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::S_ALU_WB: begin
                ctrl.rf_wd_src = rv_pkg::RF_WD_SRC_RES;
                ctrl.rf_we     = 1'b1;
            end
            rv_pkg::S_BRANCH: begin
                ctrl.alu_ctrl = rv_pkg::ALU_SUB;           // rs1 - rs2 for zero flag
                // funct3[0] picks bne over beq
                ctrl.en_npc_r = funct3[0] ? ~flags.zero : flags.zero;
            end
            rv_pkg::S_JAL: begin
                ctrl.en_npc_r  = 1'b1;                     // Target from ALU out
                ctrl.rf_wd_src = rv_pkg::RF_WD_SRC_PC;     // Link
                ctrl.rf_we     = 1'b1;
            end
            rv_pkg::S_LUI: begin
                ctrl.imm_src   = rv_pkg::IMM_U;
                ctrl.rf_wd_src = rv_pkg::RF_WD_SRC_IMM;
                ctrl.rf_we     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- cpu_top.sv
// Core top level joining the controller and datapath onto one memory port
`timescale 1ns/1ps
`include "rv_cfg.svh"

module cpu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_XLEN-1:0] m_rd,   // Combinational read data for mem.addr
    output rv_pkg::mem_req_t    mem
);
    rv_pkg::dp_ctrl_t    ctrl;
    rv_pkg::alu_flags_t  alu_flags;
    logic [`RV_XLEN-1:0] instr;

    control_fsm ctl (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (alu_flags),
        .ctrl  (ctrl),
        .m_we  (mem.we)
    );

    datapath_multicycle dp (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .m_rd      (m_rd),
        .m_addr    (mem.addr),
        .m_wd      (mem.wd),
        .instr     (instr),
        .pc        (),
        .alu_flags (alu_flags)
    );

endmodule

//--- tb_checker.sv
// Store checker stepping an instruction-level RV32I model against the core's stores
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_checker #(
    parameter logic [31:0] DATA_BASE   = 32'h0000_0400,
    parameter logic [31:0] DONE_ADDR   = 32'h0000_0bf0,
    parameter logic [31:0] DONE_MARKER = 32'h600d_f00d
) (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::mem_req_t mem,
    input  logic [31:0]      image [`RV_MEM_WORDS],
    output logic             finished,
    output int               errors
);
    localparam int IW         = $clog2(`RV_MEM_WORDS);
    localparam int NTESTS     = 6;
    localparam int STEP_LIMIT = 4 * `RV_MEM_WORDS;  // No store within this means a runaway model

    logic [31:0] model_mem [`RV_MEM_WORDS];
    logic [31:0] x [32];
    logic [31:0] model_pc;
    logic        st_valid;      // Last step was a store
    logic [31:0] st_addr;
    logic [31:0] st_data;
    int          checked [NTESTS];
    int          failed [NTESTS];
    int          dut_stores;
    int          model_stores;
    logic        done_seen;
    int          tail;          // Cycles watched after the marker

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // Signed compare
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Execute the instruction at model_pc
    function automatic void exec_one();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] pc4;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [4:0]  rd;
        ins      = model_mem[model_pc[IW+1:2]];
        a        = x[ins[19:15]];
        b        = x[ins[24:20]];
        rd       = ins[11:7];
        pc4      = model_pc + 32'd4;
        imm_i    = {{20{ins[31]}}, ins[31:20]};
        imm_b    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        st_valid = 1'b0;
        model_pc = pc4;
        case (rv_pkg::opcode_e'(ins[6:0]))
            rv_pkg::OPC_LOAD: begin
                ea    = a + imm_i;
                x[rd] = model_mem[ea[IW+1:2]];
            end
            rv_pkg::OPC_STORE: begin
                ea                   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                model_mem[ea[IW+1:2]] = b;
                st_valid             = 1'b1;
                st_addr              = ea;
                st_data              = b;
            end
            rv_pkg::OPC_OP:     x[rd] = alu_ref(ins[14:12], ins[30], a, b);
            rv_pkg::OPC_OP_IMM: x[rd] = alu_ref(ins[14:12], 1'b0, a, imm_i);
            rv_pkg::OPC_BRANCH: begin
                if ((a == b) != ins[12])   // funct3 bit 0 flips beq into bne
                    model_pc = pc4 - 32'd4 + imm_b;
            end
            rv_pkg::OPC_JAL: begin
                x[rd]    = pc4;
                model_pc = pc4 - 32'd4 + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_pkg::OPC_LUI: x[rd] = {ins[31:12], 12'b0};
            default: ;
        endcase
        x[0] = '0;  // x0 stays zero
    endfunction

    // Test index from the data area of a store
    function automatic logic [2:0] test_of(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - DATA_BASE;
        if (addr == DONE_ADDR || off >= 32'd1280)
            return 3'd5;
        return 3'(off >> 8);
    endfunction

    function automatic string test_name(input int k);
        case (k)
            0:       return "arithmetic";
            1:       return "loads";
            2:       return "branches";
            3:       return "jal and lui";
            4:       return "x0 writes";
            default: return "completion";
        endcase
    endfunction

    task automatic report();
        int k;
        int passed;
        passed = 0;
        if (dut_stores != model_stores) begin
            $display("Store count differs: core %0d, model %0d", dut_stores, model_stores);
            failed[5]++;
        end
        for (k = 0; k < NTESTS; k++) begin
            if (checked[k] > 0 && failed[k] == 0)
                passed++;
            else
                errors++;
            $display("%s: %0d stores checked, %0d mismatches, %s", test_name(k),
                     checked[k], failed[k], (checked[k] > 0 && failed[k] == 0) ? "ok" : "failed");
        end
        $display("%0d of %0d tests passed, %0d stores seen", passed, NTESTS, dut_stores);
    endtask

    initial begin
        int i;
        finished     = 1'b0;
        errors       = 0;
        dut_stores   = 0;
        model_stores = 0;
        done_seen    = 1'b0;
        tail         = 0;
        for (i = 0; i < NTESTS; i++) begin
            checked[i] = 0;
            failed[i]  = 0;
        end
        @(negedge reset);  // Program complete by now
        for (i = 0; i < `RV_MEM_WORDS; i++)
            model_mem[IW'(i)] = image[IW'(i)];
        for (i = 0; i < 32; i++)
            x[5'(i)] = '0;
        model_pc = `RV_RESET_PC;
    end

    // Sampled mid-cycle before the write lands on the next rising edge
    always @(negedge clk) begin
        int steps;
        logic [2:0] t;
        if (!reset && mem.we && !finished) begin
            dut_stores++;
            if (done_seen) begin
                $display("Core stored to %h after the done marker at %0t", mem.addr, $time);
            end else begin
                steps    = 0;
                st_valid = 1'b0;
                while (!st_valid && steps < STEP_LIMIT) begin
                    exec_one();
                    steps++;
                end
                if (!st_valid) begin
                    $display("Model ran %0d instructions without reaching a store", steps);
                    failed[5]++;
                    done_seen = 1'b1;
                end else begin
                    model_stores++;
                    t = test_of(st_addr);
                    checked[t]++;
                    if (mem.addr !== st_addr || mem.wd !== st_data) begin
                        $display("ERROR %0t: store %0d want addr %h data %h, got addr %h data %h",
                                 $time, dut_stores, st_addr, st_data, mem.addr, mem.wd);
                        failed[t]++;
                    end
                    if (st_addr == DONE_ADDR && st_data == DONE_MARKER)
                        done_seen = 1'b1;
                end
            end
        end
        // Watch a little longer for stray stores
        if (done_seen && !finished) begin
            tail++;
            if (tail == 20) begin
                report();
                finished = 1'b1;
            end
        end
    end

endmodule

//--- tb_top.sv
// Testbench top with clock, reset, memory model, program generator and watchdog
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_top;
    localparam int          IW          = $clog2(`RV_MEM_WORDS);  // Word index bits
    localparam logic [31:0] DATA_BASE   = 32'h0000_0400;          // Data region above code
    localparam logic [31:0] DONE_OFF    = 32'h0000_07f0;
    localparam logic [31:0] DONE_MARKER = 32'h600d_f00d;          // Bit 11 clear for lui and addi
    localparam int          NUM_BLOCKS  = 40;
    localparam logic [6:0]  OP_IMM      = 7'b0010011;

    logic                clk;
    logic                reset;
    logic [`RV_XLEN-1:0] m_rd;
    rv_pkg::mem_req_t    mem;
    logic [31:0]         ram [`RV_MEM_WORDS];
    logic [31:0]         lcg_state;
    int                  prog_len;      // Code words emitted
    int                  slot [8];      // Next free word per data area
    int                  arith_stores;  // Arithmetic results available for loads
    int                  branches;      // Branch blocks emitted
    int                  errors;
    logic                finished;

    cpu_top uut (
        .clk   (clk),
        .reset (reset),
        .m_rd  (m_rd),
        .mem   (mem)
    );

    tb_checker #(
        .DATA_BASE   (DATA_BASE),
        .DONE_ADDR   (DATA_BASE + DONE_OFF),
        .DONE_MARKER (DONE_MARKER)
    ) chk (
        .clk      (clk),
        .reset    (reset),
        .mem      (mem),
        .image    (ram),
        .finished (finished),
        .errors   (errors)
    );

    assign m_rd = ram[mem.addr[IW+1:2]];  // Combinational word read

    always @(posedge clk) begin
        if (mem.we)
            ram[mem.addr[IW+1:2]] <= mem.wd;
    end

    // Linear congruential step
    function automatic logic [31:0] rnd();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return (rnd() >> 8) % n;
    endfunction

    function automatic logic [4:0] any_reg();
        return 5'(1 + pick(15));  // x1..x15 only
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic emit(input logic [31:0] word);
        ram[IW'(prog_len)] = word;
        prog_len++;
    endtask

    // sw rs into the next word of one data area off x31
    task automatic store_to(input logic [4:0] rs, input logic [2:0] area);
        int off;
        off = 256 * int'(area) + 4 * slot[area];
        slot[area] = (slot[area] + 1) % 64;
        emit(enc_s(12'(off), rs, 5'd31));
    endtask

    // One random R-type or I-type operation into rd
    task automatic emit_alu(input logic [4:0] rd);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'(pick(8));
        if (pick(2) == 0) begin
            if (f3 == 3'd3)
                f3 = 3'd2;                                 // No sltu so more slt
            f7 = (f3 == 3'd0 && pick(2) == 0) ? 7'h20 : 7'h00;  // sub half the time
            emit(enc_r(f7, any_reg(), any_reg(), f3, rd));
        end else begin
            if (f3[0] && f3 != 3'd7)
                f3[0] = 1'b0;                              // addi, slti, xori, ori, andi
            emit(enc_i(12'(rnd() >> 20), any_reg(), f3, rd, OP_IMM));
        end
    endtask

    task automatic gen_block(input int kind);
        logic [4:0] r;
        logic [4:0] r2;
        logic [2:0] f3;
        r = any_reg();
        case (kind)
            0: begin
                emit_alu(r);
                store_to(r, 3'd0);
                if (arith_stores < 64)
                    arith_stores++;
            end
            1: begin
                // Read back an earlier arithmetic result
                emit(enc_i(12'(4 * pick(arith_stores > 0 ? arith_stores : 1)), 5'd31,
                           3'b010, r, 7'b0000011));
                store_to(r, 3'd1);
            end
            2: begin
                if (branches < 4) begin
                    // beq and bne on an equal pair first, then on x31 against x0
                    r2 = (branches < 2) ? r : 5'd0;
                    r  = (branches < 2) ? r : 5'd31;      // x31 holds the nonzero data base
                    f3 = 3'(branches % 2);
                end else begin
                    r2 = (pick(2) == 0) ? r : any_reg();   // Equal operands half the time
                    f3 = 3'(pick(2));
                end
                branches++;
                emit(enc_b(13'd12, r2, r, f3));            // beq or bne over two words
                store_to(5'd20, 3'd2);                     // Skipped when taken
                emit(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OP_IMM));
                store_to(5'd20, 3'd2);
            end
            3: begin
                emit(enc_j(21'd8, r));
                store_to(5'd20, 3'd3);  // Never reached
                store_to(r, 3'd3);      // Link value
                r2 = any_reg();
                emit(enc_u(20'(rnd() >> 12), r2));
                store_to(r2, 3'd3);
            end
            default: begin
                emit_alu(5'd0);         // Result must vanish
                store_to(5'd0, 3'd4);
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int i;
        reset        = 1'b1;
        lcg_state    = 32'hb86f;
        prog_len     = 0;
        arith_stores = 0;
        branches     = 0;
        for (i = 0; i < 8; i++)
            slot[i] = 0;
        for (i = 0; i < `RV_MEM_WORDS; i++)
            ram[IW'(i)] = (32'(i) * 32'h9e37_79b1) ^ 32'ha5c3_0f1e;  // Address-dependent fill
        emit(enc_i(DATA_BASE[11:0], 5'd0, 3'b000, 5'd31, OP_IMM));
        for (i = 1; i <= 15; i++) begin
            emit(enc_u(20'(rnd() >> 12), 5'(i)));
            emit(enc_i(12'(rnd() >> 20), 5'(i), 3'b000, 5'(i), OP_IMM));
        end
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd20, OP_IMM));  // Branch block counter
        // Every kind once and three more branch blocks
        for (i = 0; i < NUM_BLOCKS; i++)
            gen_block(i < 5 ? i : (i < 8 ? 2 : int'(pick(5))));
        // Done marker and a jal to itself
        emit(enc_u(DONE_MARKER[31:12], 5'd30));
        emit(enc_i(DONE_MARKER[11:0], 5'd30, 3'b000, 5'd30, OP_IMM));
        emit(enc_s(DONE_OFF[11:0], 5'd30, 5'd31));
        emit(enc_j(21'd0, 5'd0));
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        wait (finished);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // At most five clocks per instruction plus slack
    initial begin
        #1;
        repeat (8 + prog_len * 5 + 200) @(posedge clk);
        $display("Watchdog expired: the program never reached its end");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
rv_pkg.sv
alu.sv
extend.sv
regfile.sv
datapath_multicycle.sv
control_fsm.sv
cpu_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
SIM   := verilator
TOP   := tb_top
FLIST := all.f
FLAGS := --binary --timing -j 0 --top-module $(TOP)
SRCS  := $(filter-out +%,$(shell cat $(FLIST))) rv_cfg.svh
BIN   := obj_dir/V$(TOP)
LOG   := sim.log

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
